/* logic/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // ----------------------------------------
    // Geometry.
    // ----------------------------------------
    localparam int ADDR_W         = 32;
    localparam int REG_W          = 64;
    localparam int WORD_W         = 32;
    localparam int WAYS           = 4;
    localparam int SETS           = 16;
    localparam int WORDS_PER_LINE = 16;
    localparam int LINE_W         = WORDS_PER_LINE * WORD_W;
    localparam int LINE_BYTES     = LINE_W / 8;

    // Address field widths.
    localparam int WAY_W   = $clog2(WAYS);
    localparam int INDEX_W = $clog2(SETS);
    localparam int WOFF_W  = $clog2(WORDS_PER_LINE);
    localparam int BOFF_W  = $clog2(WORD_W / 8);
    localparam int TAG_W   = ADDR_W - INDEX_W - WOFF_W - BOFF_W;

    // ----------------------------------------
    // Types.
    // ----------------------------------------
    typedef logic [WAY_W-1:0]      way_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [LINE_W-1:0]     line_t;
    typedef logic [LINE_BYTES-1:0] line_be_t;

    // Overlays a full request address, tag at the top.
    typedef struct packed {
        tag_t              tag;
        index_t            index;
        logic [WOFF_W-1:0] woff;
        logic [BOFF_W-1:0] boff;
    } addr_fields_t;

    // Store width, same code as the core's store type.
    typedef enum logic [1:0] {
        ST_B = 2'd0,
        ST_H = 2'd1,
        ST_W = 2'd2,
        ST_D = 2'd3
    } store_size_e;

endpackage

`default_nettype wire

/* logic/dcache_tag_array.sv */
`default_nettype none
`timescale 1ns/100ps

module dcache_tag_array (
    input  logic                 clk,
    input  logic                 arstn,
    input  dcache_pkg::index_t   i_index,
    input  dcache_pkg::tag_t     i_tag,
    input  dcache_pkg::way_t     i_victim,
    input  dcache_pkg::way_t     i_sel_way,
    input  logic                 i_fill,
    input  logic                 i_store,
    input  logic                 i_valid_set,
    output logic                 o_hit,
    output dcache_pkg::way_t     o_hit_way,
    output logic                 o_victim_dirty,
    output dcache_pkg::tag_t     o_victim_tag
);

    dcache_pkg::tag_t tag_mem [dcache_pkg::SETS][dcache_pkg::WAYS];

    logic [dcache_pkg::SETS-1:0][dcache_pkg::WAYS-1:0] valid_q;
    logic [dcache_pkg::SETS-1:0][dcache_pkg::WAYS-1:0] dirty_q;

    logic [dcache_pkg::WAYS-1:0] match;

    // ----------------------------------------
    // Lookup.
    // ----------------------------------------
    always_comb begin
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            match[w] = valid_q[i_index][w] && (tag_mem[i_index][w] == i_tag);
        end
    end

    // Lowest matching way wins.
    always_comb begin
        o_hit_way = '0;
        for (int w = dcache_pkg::WAYS - 1; w >= 0; w--) begin
            if (match[w]) begin
                o_hit_way = dcache_pkg::way_t'(w);
            end
        end
    end

    assign o_hit          = |match;
    assign o_victim_dirty = dirty_q[i_index][i_victim];
    assign o_victim_tag   = tag_mem[i_index][i_victim];

    // ----------------------------------------
    // Update.
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (i_fill) begin
            tag_mem[i_index][i_victim] <= i_tag;
        end
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            valid_q <= '0;
        end else if (i_valid_set) begin
            valid_q[i_index][i_victim] <= 1'b1;
        end
    end

    // Store marks the line, refill cleans it.
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            dirty_q <= '0;
        end else if (i_store) begin
            dirty_q[i_index][i_sel_way] <= 1'b1;
        end else if (i_fill) begin
            dirty_q[i_index][i_victim] <= 1'b0;
        end
    end

    // A tag lives in one way of a set at most.
    a_single_match: assert property (
        @(posedge clk) disable iff (!arstn) $onehot0(match)
    );

endmodule

`default_nettype wire

/* logic/dcache_lru.sv */
`default_nettype none
`timescale 1ns/100ps

module dcache_lru (
    input  logic               clk,
    input  logic               arstn,
    input  dcache_pkg::index_t i_index,
    input  logic               i_update,
    input  logic               i_hit,
    input  dcache_pkg::way_t   i_hit_way,
    output dcache_pkg::way_t   o_victim
);

    // Age 0 is least recent, WAYS-1 is most recent.
    logic [dcache_pkg::SETS-1:0][dcache_pkg::WAYS-1:0][dcache_pkg::WAY_W-1:0] age_q;

    logic [dcache_pkg::WAYS-1:0] oldest;
    dcache_pkg::way_t            hit_age;

    // ----------------------------------------
    // Victim selection.
    // ----------------------------------------
    always_comb begin
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            oldest[w] = (age_q[i_index][w] == '0);
        end
    end

    always_comb begin
        o_victim = '0;
        for (int w = dcache_pkg::WAYS - 1; w >= 0; w--) begin
            if (oldest[w]) begin
                o_victim = dcache_pkg::way_t'(w);
            end
        end
    end

    assign hit_age = age_q[i_index][i_hit_way];

    // ----------------------------------------
    // Age update.
    // ----------------------------------------
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            for (int s = 0; s < dcache_pkg::SETS; s++) begin
                for (int w = 0; w < dcache_pkg::WAYS; w++) begin
                    age_q[s][w] <= dcache_pkg::way_t'(w);
                end
            end
        end else if (i_update && i_hit) begin
            for (int w = 0; w < dcache_pkg::WAYS; w++) begin
                if (dcache_pkg::way_t'(w) == i_hit_way) begin
                    age_q[i_index][w] <= dcache_pkg::way_t'(dcache_pkg::WAYS - 1);
                end else if (age_q[i_index][w] > hit_age) begin
                    age_q[i_index][w] <= age_q[i_index][w] - 1'b1;
                end
            end
        end
    end

    // Ages in a set stay a permutation.
    a_one_oldest: assert property (
        @(posedge clk) disable iff (!arstn) $onehot(oldest)
    );

endmodule

`default_nettype wire

/* logic/dcache_store_align.sv */
`default_nettype none
`timescale 1ns/100ps

module dcache_store_align (
    input  dcache_pkg::store_size_e          i_size,
    input  logic [dcache_pkg::WOFF_W-1:0]    i_woff,
    input  logic [dcache_pkg::BOFF_W-1:0]    i_boff,
    input  logic [dcache_pkg::REG_W-1:0]     i_data,
    output logic                             o_misaligned,
    output dcache_pkg::line_be_t             o_be,
    output dcache_pkg::line_t                o_lane_data
);

    localparam int OFF_W = dcache_pkg::WOFF_W + dcache_pkg::BOFF_W;

    logic [OFF_W-1:0] byte_off;
    logic [OFF_W-1:0] align;
    logic [OFF_W-1:0] start;
    logic [7:0]       lane_mask;

    assign byte_off = {i_woff, i_boff};

    // Size decode. Data is repeated at the store width so any aligned lane holds it.
    always_comb begin
        case (i_size)
            dcache_pkg::ST_H: begin
                lane_mask    = 8'h03;
                align        = ~OFF_W'(1);
                o_misaligned = i_boff[0];
                o_lane_data  = {(dcache_pkg::LINE_BYTES / 2){i_data[15:0]}};
            end
            dcache_pkg::ST_W: begin
                lane_mask    = 8'h0f;
                align        = ~OFF_W'(3);
                o_misaligned = |i_boff;
                o_lane_data  = {(dcache_pkg::LINE_BYTES / 4){i_data[31:0]}};
            end
            dcache_pkg::ST_D: begin
                lane_mask    = 8'hff;
                align        = ~OFF_W'(7);
                o_misaligned = (|i_boff) | i_woff[0];
                o_lane_data  = {(dcache_pkg::LINE_W / dcache_pkg::REG_W){i_data}};
            end
            default: begin
                lane_mask    = 8'h01;
                align        = '1;
                o_misaligned = 1'b0;
                o_lane_data  = {dcache_pkg::LINE_BYTES{i_data[7:0]}};
            end
        endcase
    end

    // First byte, rounded down to the store size.
    assign start = byte_off & align;
    assign o_be  = dcache_pkg::line_be_t'(lane_mask) << start;

endmodule

`default_nettype wire

/* logic/dcache_data_array.sv */
`default_nettype none
`timescale 1ns/100ps

module dcache_data_array (
    input  logic                          clk,
    input  dcache_pkg::index_t            i_index,
    input  dcache_pkg::way_t              i_sel_way,
    input  dcache_pkg::way_t              i_victim,
    input  logic                          i_store,
    input  logic                          i_fill,
    input  dcache_pkg::line_be_t          i_be,
    input  dcache_pkg::line_t             i_lane_data,
    input  dcache_pkg::line_t             i_fill_line,
    input  logic [dcache_pkg::WOFF_W-1:0] i_woff,
    output logic [dcache_pkg::REG_W-1:0]  o_word,
    output dcache_pkg::line_t             o_line
);

    dcache_pkg::line_t data_mem [dcache_pkg::SETS][dcache_pkg::WAYS];

    // Line with a zero word on top, so the last offset reads past the end.
    logic [dcache_pkg::LINE_W+dcache_pkg::WORD_W-1:0] line_ext;

    // ----------------------------------------
    // Write port.
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (i_store) begin
            for (int b = 0; b < dcache_pkg::LINE_BYTES; b++) begin
                if (i_be[b]) begin
                    data_mem[i_index][i_sel_way][b*8 +: 8] <= i_lane_data[b*8 +: 8];
                end
            end
        end else if (i_fill) begin
            data_mem[i_index][i_victim] <= i_fill_line;
        end
    end

    // ----------------------------------------
    // Read port.
    // ----------------------------------------
    assign o_line   = data_mem[i_index][i_sel_way];
    assign line_ext = {{dcache_pkg::WORD_W{1'b0}}, o_line};
    assign o_word   = line_ext[i_woff * dcache_pkg::WORD_W +: dcache_pkg::REG_W];

    // Aligner must always enable at least one byte.
    a_store_has_bytes: assert property (
        @(posedge clk) i_store |-> (|i_be)
    );

endmodule

`default_nettype wire

/* logic/data_cache.sv */
`default_nettype none
`timescale 1ns/100ps

module data_cache (
    input  logic                          clk,
    input  logic                          arstn,
    input  logic                          i_write_en,
    input  logic                          i_block_write_en,
    input  logic                          i_valid_update,
    input  logic                          i_lru_update,
    input  logic [dcache_pkg::ADDR_W-1:0] i_addr,
    input  logic [dcache_pkg::REG_W-1:0]  i_data,
    input  dcache_pkg::line_t             i_data_block,
    input  dcache_pkg::store_size_e       i_store_type,
    input  logic                          i_addr_control,
    output logic [dcache_pkg::REG_W-1:0]  o_data,
    output dcache_pkg::line_t             o_data_block,
    output logic                          o_hit,
    output logic                          o_dirty,
    output logic [dcache_pkg::ADDR_W-1:0] o_addr_axi,
    output logic                          o_store_addr_ma
);

    localparam int OFF_W = dcache_pkg::WOFF_W + dcache_pkg::BOFF_W;

    dcache_pkg::addr_fields_t addr;
    dcache_pkg::way_t         victim;
    dcache_pkg::way_t         hit_way;
    dcache_pkg::way_t         sel_way;
    dcache_pkg::tag_t         victim_tag;
    dcache_pkg::line_be_t     store_be;
    dcache_pkg::line_t        lane_data;
    logic                     fill;

    assign addr    = dcache_pkg::addr_fields_t'(i_addr);
    assign sel_way = o_hit ? hit_way : victim;
    assign fill    = i_block_write_en & ~i_write_en;

    // ----------------------------------------
    // Tags and replacement.
    // ----------------------------------------
    dcache_tag_array u_tags (
        .clk            (clk),
        .arstn          (arstn),
        .i_index        (addr.index),
        .i_tag          (addr.tag),
        .i_victim       (victim),
        .i_sel_way      (sel_way),
        .i_fill         (fill),
        .i_store        (i_write_en),
        .i_valid_set    (i_valid_update),
        .o_hit          (o_hit),
        .o_hit_way      (hit_way),
        .o_victim_dirty (o_dirty),
        .o_victim_tag   (victim_tag)
    );

    dcache_lru u_lru (
        .clk       (clk),
        .arstn     (arstn),
        .i_index   (addr.index),
        .i_update  (i_lru_update),
        .i_hit     (o_hit),
        .i_hit_way (hit_way),
        .o_victim  (victim)
    );

    // ----------------------------------------
    // Data path.
    // ----------------------------------------
    dcache_store_align u_align (
        .i_size       (i_store_type),
        .i_woff       (addr.woff),
        .i_boff       (addr.boff),
        .i_data       (i_data),
        .o_misaligned (o_store_addr_ma),
        .o_be         (store_be),
        .o_lane_data  (lane_data)
    );

    dcache_data_array u_data (
        .clk         (clk),
        .i_index     (addr.index),
        .i_sel_way   (sel_way),
        .i_victim    (victim),
        .i_store     (i_write_en),
        .i_fill      (fill),
        .i_be        (store_be),
        .i_lane_data (lane_data),
        .i_fill_line (i_data_block),
        .i_woff      (addr.woff),
        .o_word      (o_data),
        .o_line      (o_data_block)
    );

    // Refill address or write-back address of the victim.
    assign o_addr_axi = i_addr_control ? {addr.tag, addr.index, {OFF_W{1'b0}}}
                                       : {victim_tag, addr.index, {OFF_W{1'b0}}};

endmodule

`default_nettype wire

/* tb/dcache_checker.sv */
`default_nettype none
`timescale 1ns/100ps

module dcache_checker (
    input  logic                          clk,
    input  logic                          arstn,
    input  logic                          i_write_en,
    input  logic                          i_block_write_en,
    input  logic                          i_valid_update,
    input  logic                          i_lru_update,
    input  logic [dcache_pkg::ADDR_W-1:0] i_addr,
    input  logic [dcache_pkg::REG_W-1:0]  i_data,
    input  dcache_pkg::line_t             i_data_block,
    input  dcache_pkg::store_size_e       i_store_type,
    input  logic                          i_addr_control,
    input  logic [dcache_pkg::REG_W-1:0]  i_dut_data,
    input  dcache_pkg::line_t             i_dut_block,
    input  logic                          i_dut_hit,
    input  logic                          i_dut_dirty,
    input  logic [dcache_pkg::ADDR_W-1:0] i_dut_addr_axi,
    input  logic                          i_dut_ma,
    input  int                            i_test_id,
    input  logic                          i_test_done,
    input  logic                          i_all_done,
    output int                            o_errors
);

    // Compares 1 ns ahead of the rising edge.
    localparam int CHECK_DELAY = 4;

    typedef struct packed {
        logic [dcache_pkg::REG_W-1:0]  data;
        dcache_pkg::line_t             block;
        logic                          hit;
        logic                          dirty;
        logic [dcache_pkg::ADDR_W-1:0] addr_axi;
        logic                          ma;
        logic                          line_known;
        logic                          axi_known;
        dcache_pkg::way_t              sel;
        dcache_pkg::way_t              victim;
    } expect_t;

    dcache_pkg::tag_t  m_tag  [dcache_pkg::SETS][dcache_pkg::WAYS];
    dcache_pkg::line_t m_line [dcache_pkg::SETS][dcache_pkg::WAYS];
    dcache_pkg::way_t  m_age  [dcache_pkg::SETS][dcache_pkg::WAYS];
    logic [dcache_pkg::SETS-1:0][dcache_pkg::WAYS-1:0] m_valid;
    logic [dcache_pkg::SETS-1:0][dcache_pkg::WAYS-1:0] m_dirty;
    logic [dcache_pkg::SETS-1:0][dcache_pkg::WAYS-1:0] m_known;

    expect_t          now_exp;
    expect_t          upd;
    dcache_pkg::way_t hit_age;
    int               checks      = 0;
    int               errors      = 0;
    int               test_checks = 0;
    int               test_errors = 0;
    int               tests_done  = 0;

    assign o_errors = errors;

    // ----------------------------------------
    // Reference function.
    // ----------------------------------------
    function automatic expect_t predict(input logic [31:0] addr, input logic [1:0] size,
                                        input logic ctrl);
        expect_t e;
        int      ix;
        int      wo;
        logic    found;

        e     = '0;
        ix    = int'(addr[9:6]);
        wo    = int'(addr[5:2]);
        found = 1'b0;
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            if (!found && m_age[ix][w] == 2'd0) begin
                e.victim = dcache_pkg::way_t'(w);
                found    = 1'b1;
            end
        end
        e.sel = e.victim;
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            if (!e.hit && m_valid[ix][w] && m_tag[ix][w] == addr[31:10]) begin
                e.hit = 1'b1;
                e.sel = dcache_pkg::way_t'(w);
            end
        end
        e.block       = m_line[ix][e.sel];
        e.data[31:0]  = e.block[wo*32 +: 32];
        if (wo < 15) begin
            e.data[63:32] = e.block[(wo+1)*32 +: 32];
        end
        e.line_known = m_known[ix][e.sel];
        e.dirty      = m_dirty[ix][e.victim];
        case (size)
            2'd1: e.ma = addr[0];
            2'd2: e.ma = |addr[1:0];
            2'd3: e.ma = (|addr[1:0]) | addr[2];
            default: e.ma = 1'b0;
        endcase
        e.axi_known = ctrl | m_known[ix][e.victim];
        e.addr_axi  = ctrl ? {addr[31:6], 6'd0} : {m_tag[ix][e.victim], addr[9:6], 6'd0};
        return e;
    endfunction

    // Bytes of a store land from the size-aligned offset upward.
    task automatic apply_store(input int ix, input dcache_pkg::way_t way);
        int n;
        int start;

        n     = 1 << int'(i_store_type);
        start = int'(i_addr[5:0]) & ~(n - 1);
        for (int k = 0; k < n; k++) begin
            m_line[ix][way][(start+k)*8 +: 8] = i_data[k*8 +: 8];
        end
    endtask

    // ----------------------------------------
    // Model state.
    // ----------------------------------------
    always @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            m_valid = '0;
            m_dirty = '0;
            m_known = '0;
            for (int s = 0; s < dcache_pkg::SETS; s++) begin
                for (int w = 0; w < dcache_pkg::WAYS; w++) begin
                    m_age[s][w] = dcache_pkg::way_t'(w);
                end
            end
        end else begin
            upd = predict(i_addr, i_store_type, i_addr_control);
            if (i_write_en) begin
                apply_store(int'(i_addr[9:6]), upd.sel);
                m_dirty[i_addr[9:6]][upd.sel] = 1'b1;
            end else if (i_block_write_en) begin
                m_line[i_addr[9:6]][upd.victim]  = i_data_block;
                m_tag[i_addr[9:6]][upd.victim]   = i_addr[31:10];
                m_dirty[i_addr[9:6]][upd.victim] = 1'b0;
                m_known[i_addr[9:6]][upd.victim] = 1'b1;
            end
            if (i_valid_update) begin
                m_valid[i_addr[9:6]][upd.victim] = 1'b1;
            end
            if (i_lru_update && upd.hit) begin
                // Age of the hit way before this access.
                hit_age = m_age[i_addr[9:6]][upd.sel];
                for (int w = 0; w < dcache_pkg::WAYS; w++) begin
                    if (dcache_pkg::way_t'(w) == upd.sel) begin
                        m_age[i_addr[9:6]][w] = 2'd3;
                    end else if (m_age[i_addr[9:6]][w] > hit_age) begin
                        m_age[i_addr[9:6]][w] = m_age[i_addr[9:6]][w] - 2'd1;
                    end
                end
            end
        end
    end

    // ----------------------------------------
    // Comparison.
    // ----------------------------------------
    task automatic compare(input string name, input logic [511:0] exp_v,
                           input logic [511:0] act_v);
        checks++;
        test_checks++;
        if (exp_v !== act_v) begin
            errors++;
            test_errors++;
            $display("Error: %s expected 0x%0h actual 0x%0h (test %0d, %0t)",
                     name, exp_v, act_v, i_test_id, $time);
        end
    endtask

    always @(negedge clk) begin
        #(CHECK_DELAY);
        if (arstn) begin
            now_exp = predict(i_addr, i_store_type, i_addr_control);
            compare("o_hit", 512'(now_exp.hit), 512'(i_dut_hit));
            compare("o_dirty", 512'(now_exp.dirty), 512'(i_dut_dirty));
            compare("o_store_addr_ma", 512'(now_exp.ma), 512'(i_dut_ma));
            if (now_exp.axi_known) begin
                compare("o_addr_axi", 512'(now_exp.addr_axi), 512'(i_dut_addr_axi));
            end
            if (now_exp.line_known) begin
                compare("o_data", 512'(now_exp.data), 512'(i_dut_data));
                compare("o_data_block", now_exp.block, i_dut_block);
            end
            if (i_test_done) begin
                tests_done++;
                $display("test %0d done: %0d checks, %0d errors",
                         i_test_id, test_checks, test_errors);
                test_checks = 0;
                test_errors = 0;
            end
            if (i_all_done) begin
                $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
            end
        end
    end

endmodule

`default_nettype wire

/* tb/data_cache_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module data_cache_tb;

    localparam int CLK_HALF     = 5;
    localparam int RESET_CYCLES = 4;
    // Stimulus takes roughly 800 cycles.
    localparam int MAX_CYCLES   = 4000;
    localparam int FILL_SETS    = 8;

    logic                          clk = 1'b0;
    logic                          arstn;
    logic                          i_write_en;
    logic                          i_block_write_en;
    logic                          i_valid_update;
    logic                          i_lru_update;
    logic [dcache_pkg::ADDR_W-1:0] i_addr;
    logic [dcache_pkg::REG_W-1:0]  i_data;
    dcache_pkg::line_t             i_data_block;
    dcache_pkg::store_size_e       i_store_type;
    logic                          i_addr_control;
    logic [dcache_pkg::REG_W-1:0]  o_data;
    dcache_pkg::line_t             o_data_block;
    logic                          o_hit;
    logic                          o_dirty;
    logic [dcache_pkg::ADDR_W-1:0] o_addr_axi;
    logic                          o_store_addr_ma;

    int               cycles = 0;
    int               test_id;
    logic             test_done;
    logic             all_done;
    int               errors;
    logic [31:0]      lcg_state;
    dcache_pkg::tag_t slot_tag [dcache_pkg::SETS][dcache_pkg::WAYS];

    always #(CLK_HALF) clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: stimulus did not finish within %0d clock cycles", MAX_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    data_cache uut (
        .clk              (clk),
        .arstn            (arstn),
        .i_write_en       (i_write_en),
        .i_block_write_en (i_block_write_en),
        .i_valid_update   (i_valid_update),
        .i_lru_update     (i_lru_update),
        .i_addr           (i_addr),
        .i_data           (i_data),
        .i_data_block     (i_data_block),
        .i_store_type     (i_store_type),
        .i_addr_control   (i_addr_control),
        .o_data           (o_data),
        .o_data_block     (o_data_block),
        .o_hit            (o_hit),
        .o_dirty          (o_dirty),
        .o_addr_axi       (o_addr_axi),
        .o_store_addr_ma  (o_store_addr_ma)
    );

    dcache_checker u_checker (
        .clk              (clk),
        .arstn            (arstn),
        .i_write_en       (i_write_en),
        .i_block_write_en (i_block_write_en),
        .i_valid_update   (i_valid_update),
        .i_lru_update     (i_lru_update),
        .i_addr           (i_addr),
        .i_data           (i_data),
        .i_data_block     (i_data_block),
        .i_store_type     (i_store_type),
        .i_addr_control   (i_addr_control),
        .i_dut_data       (o_data),
        .i_dut_block      (o_data_block),
        .i_dut_hit        (o_hit),
        .i_dut_dirty      (o_dirty),
        .i_dut_addr_axi   (o_addr_axi),
        .i_dut_ma         (o_store_addr_ma),
        .i_test_id        (test_id),
        .i_test_done      (test_done),
        .i_all_done       (all_done),
        .o_errors         (errors)
    );

    // ----------------------------------------
    // Stimulus helpers.
    // ----------------------------------------
    // LCG, halves swapped so the low bits are usable.
    function logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    // Tag bit 2 clear for resident lines, set for a miss.
    function automatic dcache_pkg::tag_t new_tag(input int slot, input logic miss);
        logic [31:0] r;

        r = next_rand();
        return miss ? {r[31:13], 3'b100} : {r[31:13], 1'b0, 2'(slot)};
    endfunction

    function automatic logic [31:0] make_addr(input dcache_pkg::tag_t tag, input int set,
                                              input logic [5:0] off);
        return {tag, 4'(set), off};
    endfunction

    task automatic clear_strobes();
        i_write_en       = 1'b0;
        i_block_write_en = 1'b0;
        i_valid_update   = 1'b0;
        i_lru_update     = 1'b0;
    endtask

    task automatic lookup(input logic [31:0] addr, input logic ctrl, input logic touch);
        clear_strobes();
        i_addr         = addr;
        i_addr_control = ctrl;
        i_lru_update   = touch;
        @(negedge clk);
    endtask

    task automatic fill_line(input logic [31:0] addr);
        clear_strobes();
        i_addr           = addr;
        i_block_write_en = 1'b1;
        i_valid_update   = 1'b1;
        for (int k = 0; k < dcache_pkg::WORDS_PER_LINE; k++) begin
            i_data_block[k*32 +: 32] = next_rand();
        end
        @(negedge clk);
    endtask

    task automatic store_data(input logic [31:0] addr, input logic [1:0] size);
        clear_strobes();
        i_addr       = addr;
        i_write_en   = 1'b1;
        i_store_type = dcache_pkg::store_size_e'(size);
        i_data       = {next_rand(), next_rand()};
        @(negedge clk);
    endtask

    task automatic finish_test();
        clear_strobes();
        test_done = 1'b1;
        @(negedge clk);
        test_done = 1'b0;
    endtask

    // ----------------------------------------
    // Tests.
    // ----------------------------------------
    task automatic reset_lookups();
        logic [31:0] r;

        test_id = 1;
        for (int i = 0; i < 40; i++) begin
            r = next_rand();
            lookup(next_rand(), r[9], 1'b0);
        end
        finish_test();
    endtask

    task automatic fill_and_read();
        logic [31:0] r;

        test_id = 2;
        for (int s = 0; s < FILL_SETS; s++) begin
            for (int k = 0; k < dcache_pkg::WAYS; k++) begin
                slot_tag[s][k] = new_tag(k, 1'b0);
                fill_line(make_addr(slot_tag[s][k], s, 6'd0));
                lookup(make_addr(slot_tag[s][k], s, 6'd0), 1'b0, 1'b1);
            end
        end
        for (int s = 0; s < FILL_SETS; s++) begin
            for (int k = 0; k < dcache_pkg::WAYS; k++) begin
                r = next_rand();
                // Last word, upper half past the line end.
                lookup(make_addr(slot_tag[s][k], s, {4'hf, r[1:0]}), r[2], 1'b0);
                for (int j = 0; j < 3; j++) begin
                    r = next_rand();
                    lookup(make_addr(slot_tag[s][k], s, r[5:0]), r[6], 1'b0);
                end
            end
        end
        finish_test();
    endtask

    task automatic store_and_read();
        logic [31:0] r;
        logic [31:0] addr;

        test_id = 3;
        for (int i = 0; i < 120; i++) begin
            r    = next_rand();
            addr = make_addr(slot_tag[r[2:0]][r[4:3]], int'(r[2:0]),
                             r[12:7] & ~6'((1 << r[6:5]) - 1));
            store_data(addr, r[6:5]);
            lookup(addr, r[13], r[14]);
        end
        finish_test();
    endtask

    task automatic misalign_sweep();
        test_id = 4;
        for (int i = 0; i < 80; i++) begin
            i_store_type = dcache_pkg::store_size_e'(2'(i % 4));
            lookup(next_rand(), 1'b1, 1'b0);
        end
        finish_test();
    endtask

    task automatic lru_replacement();
        logic [31:0] r;
        logic [31:0] addr;
        int          order [4];
        int          j;
        int          tmp;

        test_id = 5;
        for (int s = FILL_SETS; s < dcache_pkg::SETS; s++) begin
            for (int k = 0; k < dcache_pkg::WAYS; k++) begin
                slot_tag[s][k] = new_tag(k, 1'b0);
                fill_line(make_addr(slot_tag[s][k], s, 6'd0));
                lookup(make_addr(slot_tag[s][k], s, 6'd0), 1'b0, 1'b1);
                order[k] = k;
            end
            for (int k = 0; k < dcache_pkg::WAYS; k++) begin
                r = next_rand();
                store_data(make_addr(slot_tag[s][k], s, r[7:2] & ~6'((1 << r[1:0]) - 1)),
                           r[1:0]);
            end
            // Shuffled hit order. The first way hit ends up oldest.
            for (int k = 3; k > 0; k--) begin
                j        = int'(next_rand() % 32'(k + 1));
                tmp      = order[k];
                order[k] = order[j];
                order[j] = tmp;
            end
            for (int k = 0; k < dcache_pkg::WAYS; k++) begin
                lookup(make_addr(slot_tag[s][order[k]], s, 6'd0), 1'b0, 1'b1);
            end
            addr = make_addr(new_tag(0, 1'b1), s, 6'd0);
            lookup(addr, 1'b0, 1'b0);
            lookup(addr, 1'b1, 1'b0);
            fill_line(addr);
            lookup(addr, 1'b0, 1'b0);
            lookup(addr, 1'b0, 1'b1);
        end
        finish_test();
    endtask

    initial begin
        lcg_state        = 32'h4b89_6f20;
        arstn            = 1'b0;
        i_write_en       = 1'b0;
        i_block_write_en = 1'b0;
        i_valid_update   = 1'b0;
        i_lru_update     = 1'b0;
        i_addr           = '0;
        i_data           = '0;
        i_data_block     = '0;
        i_store_type     = dcache_pkg::ST_B;
        i_addr_control   = 1'b0;
        test_id          = 0;
        test_done        = 1'b0;
        all_done         = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        arstn = 1'b1;
        reset_lookups();
        fill_and_read();
        store_and_read();
        misalign_sweep();
        lru_replacement();
        all_done = 1'b1;
        @(posedge clk);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* data_cache.f */
logic/dcache_pkg.sv
logic/dcache_tag_array.sv
logic/dcache_lru.sv
logic/dcache_store_align.sv
logic/dcache_data_array.sv
logic/data_cache.sv
tb/dcache_checker.sv
tb/data_cache_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module data_cache_tb -f data_cache.f

out=$(./obj_dir/Vdata_cache_tb)
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
    exit 0
else
    exit 1
fi
